// File: verilog/ay_pkg.sv
package ay_pkg;

	// CPU port addresses, compared under ay_decode_mask only
	localparam logic [15:0] ay_port_sel = 16'hFFFD;
	localparam logic [15:0] ay_port_data = 16'hBFFD;
	localparam logic [15:0] ay_decode_mask = 16'hC002;  // a15, a14, a1

	localparam int ay_num_regs = 16;
	localparam int ay_num_ch = 3;  // Channels A, B, C

	localparam logic [3:0] ay_reg_mixer = 4'd7;
	localparam logic [3:0] ay_reg_vol_a = 4'd8;  // B and C follow

	// ck35 pulses per tone tick
	localparam logic [4:0] ay_tick_div = 5'd16;

	// Logarithmic DAC curve, about 3 dB per step
	localparam logic [7:0] ay_vol_table [0:15] = '{
		8'h00,  // Silent
		8'h03,
		8'h04,
		8'h06,
		8'h0A,
		8'h0F,
		8'h15,
		8'h22,
		8'h28,
		8'h41,
		8'h5B,
		8'h72,
		8'h90,
		8'hB5,
		8'hD7,
		8'hFF   // Full scale
	};

endpackage

// File: verilog/ay_regs.sv
`timescale 1ns/1ps

module ay_regs import ay_pkg::*; (
	input clk28,
	input rst_n,
	input ck35,

	input [15:0] a,
	input [7:0] d,
	input iorq,
	input rd,
	input wr,
	input m1,

	output logic [7:0] d_out,
	output logic d_out_active,

	output logic [2:0][11:0] period,
	output logic [2:0][3:0] volume,
	output logic [2:0] tone_off,
	output logic tone_tick
);

// Bits that exist in each register, the rest read back as 0
function automatic logic [7:0] reg_mask(input logic [3:0] idx);
	logic [7:0] mask;
	mask = 8'hFF;
	if (idx == 4'd1 || idx == 4'd3 || idx == 4'd5)
		mask = 8'h0F;  // Coarse tone period
	else if (idx >= ay_reg_vol_a && idx <= ay_reg_vol_a + 4'd2)
		mask = 8'h1F;  // Volume plus envelope select
	return mask;
endfunction


logic io_cycle;
logic sel_hit;
logic data_hit;
logic iorq_q;
logic io_start;

assign io_cycle = iorq && !m1;  // Interrupt acknowledge is not an I/O access
assign sel_hit = (a & ay_decode_mask) == (ay_port_sel & ay_decode_mask);
assign data_hit = (a & ay_decode_mask) == (ay_port_data & ay_decode_mask);
assign io_start = io_cycle && wr && !iorq_q;  // First edge of the cycle only

always_ff @(posedge clk28 or negedge rst_n) begin
	if (!rst_n)
		iorq_q <= 1'b0;
	else
		iorq_q <= iorq;
end


logic [3:0] reg_sel;
logic [7:0] regs [0:ay_num_regs-1];

always_ff @(posedge clk28 or negedge rst_n) begin
	if (!rst_n) begin
		reg_sel <= 4'd0;
		for (int i = 0; i < ay_num_regs; i++)
			regs[i] <= (i == ay_reg_mixer) ? 8'hFF : 8'h00;  // All tones off
	end
	else if (io_start) begin
		if (sel_hit)
			reg_sel <= d[3:0];
		else if (data_hit)
			regs[reg_sel] <= d & reg_mask(reg_sel);
	end
end

// Readback is combinational so the data is on the bus within the same cycle
assign d_out_active = io_cycle && rd && sel_hit;
assign d_out = regs[reg_sel];


logic [4:0] tick_cnt;

always_ff @(posedge clk28 or negedge rst_n) begin
	if (!rst_n) begin
		tick_cnt <= 5'd0;
		tone_tick <= 1'b0;
	end
	else begin
		tone_tick <= 1'b0;
		if (ck35) begin
			if (tick_cnt == ay_tick_div - 5'd1) begin
				tick_cnt <= 5'd0;
				tone_tick <= 1'b1;
			end
			else begin
				tick_cnt <= tick_cnt + 5'd1;
			end
		end
	end
end


// Per channel fields
always_comb begin
	for (int ch = 0; ch < ay_num_ch; ch++) begin
		period[ch] = {regs[2*ch+1][3:0], regs[2*ch]};
		volume[ch] = regs[ay_reg_vol_a + 4'(ch)][3:0];  // Bit 4 is the envelope select
		tone_off[ch] = regs[ay_reg_mixer][ch];
	end
end

endmodule

// File: verilog/ay_tone.sv
`timescale 1ns/1ps

module ay_tone import ay_pkg::*; (
	input clk28,
	input rst_n,

	input tone_tick,
	input [11:0] period,
	input [3:0] volume,
	input tone_off,

	output logic [7:0] level
);

logic [11:0] cnt;
logic [11:0] cnt_next;
logic [11:0] period_eff;
logic square;
logic gate;

assign period_eff = (period == 12'd0) ? 12'd1 : period;  // Period 0 plays as 1
assign cnt_next = cnt + 12'd1;

// A disabled tone holds the channel open, as on the real chip
assign gate = square || tone_off;


// Compare with >= so that a shorter period written mid count takes effect at once
always_ff @(posedge clk28 or negedge rst_n) begin
	if (!rst_n) begin
		cnt <= 12'd0;
		square <= 1'b0;
	end
	else if (tone_tick) begin
		if (cnt_next >= period_eff) begin
			cnt <= 12'd0;
			square <= ~square;
		end
		else begin
			cnt <= cnt_next;
		end
	end
end


always_ff @(posedge clk28 or negedge rst_n) begin
	if (!rst_n)
		level <= 8'h00;
	else if (gate)
		level <= ay_vol_table[volume];
	else
		level <= 8'h00;
end

endmodule

// File: verilog/ay_mixer.sv
`timescale 1ns/1ps

module ay_mixer (
	input clk28,
	input rst_n,

	input [2:0][7:0] level,

	output logic dac_l,
	output logic dac_r
);

// Average of two channels, never overflows 8 bits
function automatic logic [7:0] half_sum(input logic [7:0] x, input logic [7:0] y);
	logic [8:0] sum;
	sum = {1'b0, x} + {1'b0, y};
	return sum[8:1];
endfunction

// One sigma-delta step, carry out is the pulse
function automatic logic [8:0] sd_step(input logic [7:0] acc, input logic [7:0] x);
	logic [8:0] next;
	next = {1'b0, acc} + {1'b0, x};
	return next;
endfunction


logic [7:0] mix_l;
logic [7:0] mix_r;

// ABC layout with B shared by both sides
always_ff @(posedge clk28 or negedge rst_n) begin
	if (!rst_n) begin
		mix_l <= 8'h00;
		mix_r <= 8'h00;
	end
	else begin
		mix_l <= half_sum(level[0], level[1]);  // A + B
		mix_r <= half_sum(level[2], level[1]);  // C + B
	end
end


logic [7:0] acc_l;
logic [7:0] acc_r;
logic [8:0] step_l;
logic [8:0] step_r;

assign step_l = sd_step(acc_l, mix_l);
assign step_r = sd_step(acc_r, mix_r);

// Runs every clk28 for the highest pulse rate
always_ff @(posedge clk28 or negedge rst_n) begin
	if (!rst_n) begin
		acc_l <= 8'h00;
		acc_r <= 8'h00;
		dac_l <= 1'b0;
		dac_r <= 1'b0;
	end
	else begin
		acc_l <= step_l[7:0];
		acc_r <= step_r[7:0];
		dac_l <= step_l[8];
		dac_r <= step_r[8];
	end
end

endmodule

// File: verilog/ay_sound.sv
`timescale 1ns/1ps

module ay_sound import ay_pkg::*; (
	input clk28,
	input rst_n,
	input ck35,

	input [15:0] a,
	input [7:0] d,
	input iorq,
	input rd,
	input wr,
	input m1,

	output [7:0] d_out,
	output d_out_active,

	output dac_l,
	output dac_r
);

logic [2:0][11:0] period;
logic [2:0][3:0] volume;
logic [2:0] tone_off;
logic tone_tick;
logic [2:0][7:0] level;


ay_regs regs0 (
	.clk28(clk28),
	.rst_n(rst_n),
	.ck35(ck35),

	.a(a),
	.d(d),
	.iorq(iorq),
	.rd(rd),
	.wr(wr),
	.m1(m1),

	.d_out(d_out),
	.d_out_active(d_out_active),

	.period(period),
	.volume(volume),
	.tone_off(tone_off),
	.tone_tick(tone_tick)
);


// Channel 0 is A, 1 is B, 2 is C
generate
	for (genvar ch = 0; ch < ay_num_ch; ch++) begin : g_tone
		ay_tone tone (
			.clk28(clk28),
			.rst_n(rst_n),

			.tone_tick(tone_tick),
			.period(period[ch]),
			.volume(volume[ch]),
			.tone_off(tone_off[ch]),

			.level(level[ch])
		);
	end
endgenerate


ay_mixer mixer0 (
	.clk28(clk28),
	.rst_n(rst_n),

	.level(level),

	.dac_l(dac_l),
	.dac_r(dac_r)
);

endmodule

// File: testbench/ay_sound_assertions.sv
`timescale 1ns/1ps

module ay_sound_assertions (
	input clk28,
	input rst_n,
	input iorq,
	input rd,
	input m1,
	input d_out_active,
	input dac_l,
	input dac_r
);

int fail_count = 0;  // Read by the testbench at the end of the run

active_needs_read: assert property (@(posedge clk28) disable iff (!rst_n)
	d_out_active |-> iorq && rd)
	else begin
		$error("d_out_active high without iorq and rd");
		fail_count++;
	end

active_not_in_m1: assert property (@(posedge clk28) disable iff (!rst_n)
	d_out_active |-> !m1)
	else begin
		$error("d_out_active high during an M1 cycle");
		fail_count++;
	end

dac_quiet_in_reset: assert property (@(posedge clk28) !rst_n |-> !dac_l && !dac_r)
	else begin
		$error("DAC output high during reset");
		fail_count++;
	end

endmodule

bind ay_sound ay_sound_assertions chk (.*);

// File: testbench/tb_ay_sound.sv
`timescale 1ns/1ps

module tb_ay_sound import ay_pkg::*; ();

localparam int bus_cycles = 160 * 5;  // About 160 bus accesses of 5 cycles
localparam int level_cycles = 3 * (64 + 256);
localparam int tone_cycles = 768 * (1 + 3) + 2 * 64;  // Settle plus two square periods
localparam int run_cycles = 16 + bus_cycles + level_cycles + tone_cycles;

logic clk28, rst_n, ck35, iorq, rd, wr, m1;
logic [15:0] a;
logic [7:0] d;
wire [7:0] d_out;
wire d_out_active, dac_l, dac_r;
logic [15:0] lfsr = 16'd27882;
int checks = 0;
int errors = 0;
int checks_at_start, errors_at_start;

ay_sound dut (.*);

initial begin
	clk28 = 1'b0;
	forever #5 clk28 = ~clk28;
end

// One ck35 pulse every 8 clk28 cycles
initial begin
	ck35 = 1'b0;
	forever begin
		repeat (7) @(posedge clk28);
		#1 ck35 = 1'b1;
		@(posedge clk28);
		#1 ck35 = 1'b0;
	end
end

initial begin
	#(2 * run_cycles * 10);
	$display("Watchdog expired, the run did not finish in time");
	$display("test failed");
	$finish;
end

function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

task automatic take_bits(input int n, output logic [7:0] val);
	val = 8'h00;
	for (int i = 0; i < n; i++) begin
		val = {val[6:0], lfsr[0]};
		lfsr = lfsr_next(lfsr);
	end
endtask

function automatic logic [7:0] used_bits(input int idx);
	case (idx)
		1, 3, 5: return 8'h0F;  // Coarse period
		8, 9, 10: return 8'h1F;  // Volume and envelope select
		default: return 8'hFF;
	endcase
endfunction

task automatic check_near(input string name, input int expected, input int actual, input int tol);
	checks++;
	assert (actual >= expected - tol && actual <= expected + tol) else begin
		errors++;
		$display("[FAIL] %s expected %0d (+-%0d) actual %0d", name, expected, tol, actual);
	end
endtask

task automatic io_write(input logic [15:0] addr, input logic [7:0] data, input logic m1_val);
	@(posedge clk28);
	#1;
	a = addr;
	d = data;
	m1 = m1_val;
	iorq = 1'b1;
	wr = 1'b1;
	repeat (4) @(posedge clk28);
	#1;
	iorq = 1'b0;
	wr = 1'b0;
	m1 = 1'b0;
endtask

task automatic io_read(input logic [15:0] addr, input logic m1_val,
	output logic [7:0] data, output logic active);
	@(posedge clk28);
	#1;
	a = addr;
	m1 = m1_val;
	iorq = 1'b1;
	rd = 1'b1;
	repeat (3) @(posedge clk28);
	@(negedge clk28);
	data = d_out;
	active = d_out_active;
	@(posedge clk28);
	#1;
	iorq = 1'b0;
	rd = 1'b0;
	m1 = 1'b0;
endtask

task automatic write_reg(input logic [3:0] idx, input logic [7:0] val);
	io_write(ay_port_sel, {4'h0, idx}, 1'b0);
	io_write(ay_port_data, val, 1'b0);
endtask

task automatic read_reg(input logic [3:0] idx, output logic [7:0] val);
	logic active;
	io_write(ay_port_sel, {4'h0, idx}, 1'b0);
	io_read(ay_port_sel, 1'b0, val, active);
endtask

task automatic count_ones(input int n, output int nl, output int nr);
	nl = 0;
	nr = 0;
	repeat (n) begin
		@(negedge clk28);
		nl += dac_l;
		nr += dac_r;
	end
endtask

task automatic start_test();
	checks_at_start = checks;
	errors_at_start = errors;
endtask

task automatic end_test(input string name);
	int n;
	n = checks - checks_at_start;
	$display("%s: %0d of %0d checks ok", name, n - (errors - errors_at_start), n);
endtask

// All tones off, so each level is set by its volume alone
task automatic level_check(input string name, input logic [3:0] va, input logic [3:0] vb,
	input logic [3:0] vc, input int exp_l, input int exp_r);
	int nl, nr;
	write_reg(ay_reg_mixer, 8'hFF);
	write_reg(ay_reg_vol_a, {4'h0, va});
	write_reg(ay_reg_vol_a + 4'd1, {4'h0, vb});
	write_reg(ay_reg_vol_a + 4'd2, {4'h0, vc});
	repeat (64) @(posedge clk28);
	count_ones(256, nl, nr);
	check_near({name, "_l"}, exp_l, nl, (exp_l == 0) ? 0 : 1);
	check_near({name, "_r"}, exp_r, nr, (exp_r == 0) ? 0 : 1);
endtask

task automatic tone_check(input int p);
	int nl, nr, window, static_cnt;
	window = 16 * 8 * 2 * p * 2;
	static_cnt = (ay_vol_table[15] / 2) * window / 256;
	write_reg(4'd0, p[7:0]);
	write_reg(4'd1, {4'h0, p[11:8]});
	write_reg(ay_reg_vol_a, 8'd15);
	write_reg(ay_reg_vol_a + 4'd1, 8'd0);
	write_reg(ay_reg_vol_a + 4'd2, 8'd0);
	write_reg(ay_reg_mixer, 8'hFE);  // Tone A on
	repeat (256 * p + 64) @(posedge clk28);
	count_ones(window, nl, nr);
	check_near($sformatf("tone_p%0d_l", p), static_cnt / 2, nl, 4);  // Four square edges
	check_near($sformatf("tone_p%0d_r", p), 0, nr, 0);
endtask

initial begin
	logic [7:0] val;
	logic [7:0] data [0:15];
	logic [15:0] bad [0:3];
	logic [3:0] v;
	logic act;
	rst_n = 1'b0;
	a = 16'h0000;
	d = 8'h00;
	{iorq, rd, wr, m1} = 4'b0000;
	bad = '{16'h3FFD, 16'h7FFD, 16'hBFFF, 16'hFFFF};  // a15, a14 or a1 off the ports
	repeat (16) @(posedge clk28);
	#1 rst_n = 1'b1;

	start_test();
	read_reg(ay_reg_mixer, val);
	check_near("reset_mixer", 8'hFF, val, 0);
	for (int i = 0; i < 3; i++) begin
		read_reg(ay_reg_vol_a + 4'(i), val);
		check_near($sformatf("reset_vol%0d", i), 0, val, 0);
	end
	end_test("reset");

	start_test();
	for (int i = 0; i < 16; i++) begin
		take_bits(8, data[i]);
		write_reg(4'(i), data[i]);
	end
	for (int i = 0; i < 16; i++) begin
		read_reg(4'(i), val);
		check_near($sformatf("readback_r%0d", i), data[i] & used_bits(i), val, 0);
	end
	end_test("readback");

	start_test();
	write_reg(4'd0, 8'h5A);
	for (int i = 0; i < 4; i++) begin
		io_write(bad[i], 8'h03, 1'b0);
		io_read(bad[i], 1'b0, val, act);
		check_near($sformatf("decode_active_%h", bad[i]), 0, act, 0);
	end
	io_write(ay_port_data, 8'hA5, 1'b1);
	io_write(ay_port_sel, 8'h03, 1'b1);
	io_read(ay_port_sel, 1'b1, val, act);
	check_near("decode_active_m1", 0, act, 0);
	io_read(ay_port_sel, 1'b0, val, act);
	check_near("decode_active_sel", 1, act, 0);
	check_near("decode_r0", 8'h5A, val, 0);
	end_test("decode");

	start_test();
	take_bits(4, val);
	v = val[3:0] | 4'd8;
	level_check("static_a", v, 4'd0, 4'd0, ay_vol_table[v] / 2, 0);
	end_test("static_level");

	start_test();
	take_bits(4, val);
	v = val[3:0] | 4'd8;
	level_check("stereo_b", 4'd0, v, 4'd0, ay_vol_table[v] / 2, ay_vol_table[v] / 2);
	take_bits(4, val);
	v = val[3:0] | 4'd8;
	level_check("stereo_c", 4'd0, 4'd0, v, 0, ay_vol_table[v] / 2);
	end_test("stereo");

	start_test();
	tone_check(1);
	tone_check(3);
	end_test("tone");

	$display("%0d checks, %0d failed, %0d assertion errors", checks, errors,
		dut.chk.fail_count);
	if (errors == 0 && dut.chk.fail_count == 0)
		$display("test passed");
	else
		$display("test failed");
	$finish;
end

endmodule

// File: verilog.f
verilog/ay_pkg.sv
verilog/ay_regs.sv
verilog/ay_tone.sv
verilog/ay_mixer.sv
verilog/ay_sound.sv
testbench/ay_sound_assertions.sv
testbench/tb_ay_sound.sv

// File: Bender.yml
package:
  name: ay_sound

sources:
  - verilog/ay_pkg.sv
  - verilog/ay_regs.sv
  - verilog/ay_tone.sv
  - verilog/ay_mixer.sv
  - verilog/ay_sound.sv
  - target: simulation
    files:
      - testbench/ay_sound_assertions.sv
      - testbench/tb_ay_sound.sv
